/* neopixel_pkg.sv */
package neopixel_pkg;

  // Width of the frame length register, 5 + 8 bits over two bus bytes
  localparam int max_w = 13;

  // Register offsets, decoded from the two lowest address bits
  localparam logic [1:0] reg_max_lo = 2'd0;
  localparam logic [1:0] reg_max_hi = 2'd1;
  localparam logic [1:0] reg_ctrl   = 2'd2;
  localparam logic [1:0] reg_status = 2'd3;

  // One bus access, write and read are single-cycle strobes
  typedef struct packed {
    logic [13:0] addr;
    logic [7:0]  wdata;
    logic        write;
    logic        read;
  } bus_req_t;

  // Control register, init sits in bit 0 and buf_sel in bit 5
  typedef struct packed {
    logic buf_sel;
    logic mode32;
    logic loop;
    logic run;
    logic limit;
    logic init;
  } ctrl_t;

  // Streamer FSM states
  typedef enum logic [1:0] {
    idle,
    init_low,
    send,
    latch
  } stream_state_e;

  // Commands from the streamer to the bit encoder
  typedef enum logic [1:0] {
    sym_none,
    sym_byte,
    sym_reset
  } symbol_e;

endpackage

/* neopixel_bit_encoder.sv */
`timescale 1ns/1ps

module neopixel_bit_encoder #(
  parameter int T0H    = 20,
  parameter int T1H    = 40,
  parameter int TBIT   = 63,
  parameter int TRESET = 2500,
  localparam int CNT_MAX = (TBIT > TRESET) ? TBIT : TRESET,
  localparam int CNT_W   = $clog2(CNT_MAX + 1)
) (
  input  logic                  busClk,
  input  logic                  rst,
  input  neopixel_pkg::symbol_e sym,
  input  logic [7:0]            sym_byte,
  output logic                  ready,
  output logic                  dout
);

  logic             busy;
  logic             in_reset;
  logic [7:0]       shift_q;
  logic [2:0]       bit_cnt;
  logic [CNT_W-1:0] cyc_cnt;
  logic [CNT_W-1:0] high_len;
  logic             bit_end;

  assign ready    = !busy;
  assign high_len = shift_q[7] ? CNT_W'(T1H) : CNT_W'(T0H);
  assign bit_end  = cyc_cnt == CNT_W'(TBIT - 1);

  // High at the start of each bit cell, low for the rest and during reset
  assign dout = busy && !in_reset && (cyc_cnt < high_len);

  always_ff @(posedge busClk) begin
    if (ready && sym == neopixel_pkg::sym_byte) begin
      shift_q <= sym_byte;
    end else if (busy && !in_reset && bit_end) begin
      shift_q <= {shift_q[6:0], 1'b0};
    end
  end

  always_ff @(posedge busClk) begin
    if (rst) begin
      busy     <= 1'b0;
      in_reset <= 1'b0;
      bit_cnt  <= '0;
      cyc_cnt  <= '0;
    end else if (!busy) begin
      cyc_cnt <= '0;
      bit_cnt <= 3'd7;
      if (sym != neopixel_pkg::sym_none) begin
        busy     <= 1'b1;
        in_reset <= (sym == neopixel_pkg::sym_reset);
      end
    end else if (in_reset) begin
      if (cyc_cnt == CNT_W'(TRESET - 1)) busy <= 1'b0;
      else cyc_cnt <= cyc_cnt + 1'b1;
    end else if (bit_end) begin
      cyc_cnt <= '0;
      if (bit_cnt == 3'd0) busy <= 1'b0;
      else bit_cnt <= bit_cnt - 1'b1;
    end else begin
      cyc_cnt <= cyc_cnt + 1'b1;
    end
  end

  // Pulse widths must order as 0-bit, 1-bit, whole cell
  if (!(T0H < T1H && T1H < TBIT)) begin : g_bad_timing
    $error("neopixel_bit_encoder needs T0H < T1H < TBIT");
  end

  a_high_len: assert property (@(posedge busClk) disable iff (rst)
    $rose(dout) |-> ##[1:T1H] !dout)
    else $error("dout high longer than T1H");

endmodule

/* neopixel_registers.sv */
`timescale 1ns/1ps

module neopixel_registers #(
  parameter int BUFFER_END = 63,
  localparam int IDX_W = $clog2(BUFFER_END + 1)
) (
  input  logic                            busClk,
  input  logic                            rst,
  input  neopixel_pkg::bus_req_t          bus,
  output logic [7:0]                      bus_rdata,
  input  logic                            sync_start,
  input  logic [IDX_W-1:0]                rd_addr,
  output logic [7:0]                      rd_data,
  output neopixel_pkg::ctrl_t             ctrl,
  output logic [neopixel_pkg::max_w-1:0]  reg_max,
  input  neopixel_pkg::stream_state_e     state,
  input  logic                            init_done,
  input  logic                            frame_done
);

  // Two pixel buffers, software fills one while the other is streamed
  logic [7:0] pix_mem [0:1][0:BUFFER_END];

  neopixel_pkg::ctrl_t ctrl_d;
  logic                buf_wr;
  logic                reg_wr;
  logic [IDX_W-1:0]    buf_idx;

  assign buf_wr  = bus.write && !bus.addr[13];
  assign reg_wr  = bus.write && bus.addr[13];
  assign buf_idx = bus.addr[IDX_W-1:0];

  // Streamer side sees the buffer that software is not writing
  assign rd_data = pix_mem[!ctrl.buf_sel][rd_addr];

  always_ff @(posedge busClk) begin
    if (buf_wr) begin
      pix_mem[ctrl.buf_sel][buf_idx] <= bus.wdata;
    end
  end

  // Next control value, bus first and streamer events last so they win
  always_comb begin
    ctrl_d = ctrl;
    if (reg_wr && bus.addr[1:0] == neopixel_pkg::reg_ctrl) begin
      ctrl_d = neopixel_pkg::ctrl_t'(bus.wdata[5:0]);
    end
    if (sync_start) begin
      ctrl_d.run = 1'b1;
    end
    // Init owns the control word until the strip has been reset
    if (ctrl_d.init) begin
      ctrl_d      = '0;
      ctrl_d.init = 1'b1;
    end
    if (init_done) begin
      ctrl_d.init = 1'b0;
    end
    if (frame_done) begin
      ctrl_d.run = ctrl_d.loop;
    end
  end

  always_ff @(posedge busClk) begin
    if (rst) begin
      ctrl    <= '0;
      reg_max <= '0;
    end else begin
      ctrl <= ctrl_d;
      if (reg_wr && bus.addr[1:0] == neopixel_pkg::reg_max_lo) begin
        reg_max[7:0] <= bus.wdata;
      end
      if (reg_wr && bus.addr[1:0] == neopixel_pkg::reg_max_hi) begin
        reg_max[neopixel_pkg::max_w-1:8] <= bus.wdata[neopixel_pkg::max_w-9:0];
      end
    end
  end

  // Read data lands one cycle after the strobe and holds until the next read
  always_ff @(posedge busClk) begin
    if (bus.read) begin
      if (!bus.addr[13]) begin
        // Software reads back the buffer it writes
        bus_rdata <= pix_mem[ctrl.buf_sel][buf_idx];
      end else begin
        case (bus.addr[1:0])
          neopixel_pkg::reg_max_lo: bus_rdata <= reg_max[7:0];
          neopixel_pkg::reg_max_hi: bus_rdata <= 8'(reg_max[neopixel_pkg::max_w-1:8]);
          neopixel_pkg::reg_ctrl:   bus_rdata <= 8'(ctrl);
          default:                  bus_rdata <= {7'b0, state != neopixel_pkg::idle};
        endcase
      end
    end
  end

  // Bus master never issues both strobes at once
  a_no_rd_wr: assert property (@(posedge busClk) disable iff (rst)
    !(bus.read && bus.write))
    else $error("bus read and write in the same cycle");

endmodule

/* neopixel_streamer.sv */
`timescale 1ns/1ps

module neopixel_streamer #(
  parameter int BUFFER_END = 63,
  parameter int TRESET     = 2500,
  localparam int IDX_W = $clog2(BUFFER_END + 1)
) (
  input  logic                            busClk,
  input  logic                            rst,
  input  neopixel_pkg::ctrl_t             ctrl,
  input  logic [neopixel_pkg::max_w-1:0]  reg_max,
  output logic [IDX_W-1:0]                rd_addr,
  input  logic [7:0]                      rd_data,
  output neopixel_pkg::symbol_e           sym,
  output logic [7:0]                      sym_byte,
  input  logic                            ready,
  output neopixel_pkg::stream_state_e     state,
  output logic                            init_done,
  output logic                            frame_done,
  output logic                            start_seen
);

  logic [IDX_W-1:0] last_idx;
  logic             skip;
  // Set once the reset symbol of init_low or latch has been handed over
  logic             reset_sent;

  // A max beyond the buffer falls back to the full buffer
  assign last_idx = (ctrl.limit && reg_max < BUFFER_END) ?
                    reg_max[IDX_W-1:0] : IDX_W'(BUFFER_END);

  // 24-bit pixels leave the fourth byte of each group out
  assign skip = !ctrl.mode32 && (rd_addr[1:0] == 2'b11);

  assign sym_byte = rd_data;

  always_comb begin
    sym = neopixel_pkg::sym_none;
    if (ready) begin
      case (state)
        neopixel_pkg::send: begin
          if (!skip) sym = neopixel_pkg::sym_byte;
        end
        neopixel_pkg::init_low, neopixel_pkg::latch: begin
          if (!reset_sent) sym = neopixel_pkg::sym_reset;
        end
        default: sym = neopixel_pkg::sym_none;
      endcase
    end
  end

  // Encoder back to ready after the reset symbol means the low time is over
  assign init_done  = (state == neopixel_pkg::init_low) && ready && reset_sent;
  assign frame_done = (state == neopixel_pkg::latch) && ready && reset_sent;
  assign start_seen = (state == neopixel_pkg::idle) && !ctrl.init && ctrl.run;

  always_ff @(posedge busClk) begin
    if (rst) begin
      state      <= neopixel_pkg::idle;
      rd_addr    <= '0;
      reset_sent <= 1'b0;
    end else begin
      case (state)
        neopixel_pkg::idle: begin
          rd_addr <= '0;
          if (ctrl.init) begin
            state <= neopixel_pkg::init_low;
          end else if (ctrl.run) begin
            state <= neopixel_pkg::send;
          end
        end
        neopixel_pkg::send: begin
          // Skipped bytes advance without waiting on the encoder
          if (skip || ready) begin
            if (rd_addr == last_idx) begin
              state <= neopixel_pkg::latch;
            end else begin
              rd_addr <= rd_addr + 1'b1;
            end
          end
        end
        default: begin
          if (ready) begin
            if (reset_sent) begin
              reset_sent <= 1'b0;
              state      <= neopixel_pkg::idle;
            end else begin
              reset_sent <= 1'b1;
            end
          end
        end
      endcase
    end
  end

  a_addr_range: assert property (@(posedge busClk) disable iff (rst)
    rd_addr <= BUFFER_END)
    else $error("rd_addr beyond the pixel buffer");

  // Latch low time seen from here matches the encoder reset length
  a_latch_len: assert property (@(posedge busClk) disable iff (rst)
    (state == neopixel_pkg::latch && sym == neopixel_pkg::sym_reset)
      |-> ##(TRESET + 1) frame_done)
    else $error("frame_done not one cycle after the latch period");

endmodule

/* neopixel_top.sv */
`timescale 1ns/1ps

module neopixel_top #(
  parameter int BUFFER_END = 63,
  // Cycle counts for a 50 MHz bus clock
  parameter int T0H    = 20,
  parameter int T1H    = 40,
  parameter int TBIT   = 63,
  parameter int TRESET = 2500,
  localparam int IDX_W = $clog2(BUFFER_END + 1)
) (
  input  logic                   busClk,
  input  logic                   rst,
  input  neopixel_pkg::bus_req_t bus,
  output logic [7:0]             bus_rdata,
  input  logic                   sync_start,
  output logic                   dout
);

  neopixel_pkg::ctrl_t           ctrl;
  logic [neopixel_pkg::max_w-1:0] reg_max;
  logic [IDX_W-1:0]              rd_addr;
  logic [7:0]                    rd_data;
  neopixel_pkg::stream_state_e   state;
  logic                          init_done;
  logic                          frame_done;
  logic                          start_seen;
  neopixel_pkg::symbol_e         sym;
  logic [7:0]                    sym_byte;
  logic                          ready;

  neopixel_registers #(.BUFFER_END(BUFFER_END)) i_registers (
    .busClk, .rst, .bus, .bus_rdata, .sync_start, .rd_addr, .rd_data,
    .ctrl, .reg_max, .state, .init_done, .frame_done
  );

  neopixel_streamer #(.BUFFER_END(BUFFER_END), .TRESET(TRESET)) i_streamer (
    .busClk, .rst, .ctrl, .reg_max, .rd_addr, .rd_data, .sym, .sym_byte,
    .ready, .state, .init_done, .frame_done, .start_seen
  );

  neopixel_bit_encoder #(.T0H(T0H), .T1H(T1H), .TBIT(TBIT), .TRESET(TRESET)) i_encoder (
    .busClk, .rst, .sym, .sym_byte, .ready, .dout
  );

endmodule

/* neopixel_tb.sv */
`timescale 1ns/1ps

module neopixel_tb;

  localparam int CLK_PERIOD = 4;
  localparam int BUFFER_END = 15;
  localparam int T0H        = 2;
  localparam int T1H        = 5;
  localparam int TBIT       = 8;
  localparam int TRESET     = 20;
  // Worst case frame with every byte sent and a reset period on each side
  localparam int FRAME_CYCLES = (BUFFER_END + 1) * 8 * TBIT + 2 * TRESET;

  localparam logic [13:0] a_max_lo = {12'h800, neopixel_pkg::reg_max_lo};
  localparam logic [13:0] a_max_hi = {12'h800, neopixel_pkg::reg_max_hi};
  localparam logic [13:0] a_ctrl   = {12'h800, neopixel_pkg::reg_ctrl};
  localparam logic [13:0] a_status = {12'h800, neopixel_pkg::reg_status};

  typedef enum logic [3:0] {
    op_wr, op_rd, op_rdm, op_fill, op_frame, op_busy, op_idle, op_sync, op_next
  } op_e;

  // For op_frame addr is the model bank, data is mode32 and exp the last index
  typedef struct packed {
    op_e         op;
    logic [13:0] addr;
    logic [7:0]  data;
    logic [7:0]  exp;
  } step_t;

  logic                   busClk;
  logic                   rst;
  neopixel_pkg::bus_req_t bus;
  logic [7:0]             bus_rdata;
  logic                   sync_start;
  logic                   dout;

  step_t       steps [$];
  logic [7:0]  model [0:1][0:BUFFER_END];
  logic [7:0]  rx_q [$];
  logic [31:0] seed = 32'd32457;
  int          frames = 0;
  bit          table_ready = 1'b0;

  // Pulse decoder state
  int          high_cnt = 0;
  int          low_cnt = 0;
  int          rx_bits = 0;
  logic [7:0]  rx_byte = '0;
  bit          got_bits = 1'b0;

  neopixel_top #(
    .BUFFER_END(BUFFER_END), .T0H(T0H), .T1H(T1H), .TBIT(TBIT), .TRESET(TRESET)
  ) i_dut (
    .busClk, .rst, .bus, .bus_rdata, .sync_start, .dout
  );

  initial begin
    busClk = 1'b0;
    forever #(CLK_PERIOD / 2) busClk = ~busClk;
  end

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp) begin
      $display("ERR %0t ns: %s, got %0h expected %0h", $time, msg, got, exp);
      $display("ERRORS FOUND");
      $fatal(1, "check failed");
    end
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  task automatic bus_write(input logic [13:0] addr, input logic [7:0] data);
    @(posedge busClk);
    #1 bus.addr = addr;
    bus.wdata = data;
    bus.write = 1'b1;
    @(posedge busClk);
    #1 bus.write = 1'b0;
  endtask

  // Read data is valid one cycle after the strobe
  task automatic bus_read(input logic [13:0] addr, output logic [7:0] data);
    @(posedge busClk);
    #1 bus.addr = addr;
    bus.read = 1'b1;
    @(posedge busClk);
    #1 bus.read = 1'b0;
    data = bus_rdata;
  endtask

  task automatic fill_buffer(input int bank);
    int i;
    for (i = 0; i <= BUFFER_END; i++) begin
      seed = xorshift(seed);
      model[bank][i] = seed[7:0];
      bus_write(14'(i), seed[7:0]);
    end
  endtask

  task automatic wait_status(input logic busy);
    logic [7:0] rd;
    do begin
      bus_read(a_status, rd);
    end while (rd[0] !== busy);
  endtask

  task automatic pulse_sync();
    @(posedge busClk);
    #1 sync_start = 1'b1;
    @(posedge busClk);
    #1 sync_start = 1'b0;
  endtask

  // 24-bit pixels drop every index whose two low bits are 3
  task automatic wait_frame(input int bank, input bit m32, input int last);
    int n0;
    int cnt;
    int i;
    n0 = frames;
    cnt = 0;
    wait (frames != n0);
    for (i = 0; i <= last; i++) begin
      if (m32 || i % 4 != 3) cnt++;
    end
    check(rx_q.size(), cnt, "decoded byte count");
    for (i = 0; i <= last; i++) begin
      if (m32 || i % 4 != 3) check(rx_q.pop_front(), model[bank][i], "decoded pixel byte");
    end
  endtask

  task automatic add_step(input op_e op, input logic [13:0] addr, input logic [7:0] data,
                          input logic [7:0] exp);
    steps.push_back({op, addr, data, exp});
  endtask

  task automatic build_table();
    // Register readback
    add_step(op_wr, a_max_lo, 8'h5a, 8'h00);
    add_step(op_rd, a_max_lo, 8'h00, 8'h5a);
    add_step(op_wr, a_max_hi, 8'hff, 8'h00);
    add_step(op_rd, a_max_hi, 8'h00, 8'h1f);
    add_step(op_wr, a_ctrl, 8'h28, 8'h00);
    add_step(op_rd, a_ctrl, 8'h00, 8'h28);
    add_step(op_rd, a_status, 8'h00, 8'h00);
    add_step(op_wr, a_ctrl, 8'h00, 8'h00);
    // Fill bank 0 and bank 1 on either side of a buf_sel flip
    add_step(op_fill, 14'd0, 8'd0, 8'h00);
    add_step(op_rdm, 14'd3, 8'd0, 8'h00);
    add_step(op_rdm, 14'd12, 8'd0, 8'h00);
    add_step(op_wr, a_ctrl, 8'h20, 8'h00);
    add_step(op_fill, 14'd0, 8'd1, 8'h00);
    add_step(op_rdm, 14'd3, 8'd1, 8'h00);
    add_step(op_rdm, 14'd12, 8'd1, 8'h00);
    // 24-bit frame limited to max
    add_step(op_wr, a_max_lo, 8'd9, 8'h00);
    add_step(op_wr, a_max_hi, 8'd0, 8'h00);
    add_step(op_wr, a_ctrl, 8'h26, 8'h00);
    add_step(op_frame, 14'd0, 8'd0, 8'd9);
    add_step(op_idle, 14'd0, 8'd0, 8'h00);
    add_step(op_rd, a_ctrl, 8'h00, 8'h22);
    // 32-bit frame over the whole buffer
    add_step(op_wr, a_ctrl, 8'h34, 8'h00);
    add_step(op_frame, 14'd0, 8'd1, 8'(BUFFER_END));
    add_step(op_idle, 14'd0, 8'd0, 8'h00);
    add_step(op_rd, a_ctrl, 8'h00, 8'h30);
    // Loop keeps run set until the write during the second latch
    add_step(op_wr, a_ctrl, 8'h3c, 8'h00);
    add_step(op_frame, 14'd0, 8'd1, 8'(BUFFER_END));
    // Run is read once the next frame is under way
    add_step(op_next, 14'd0, 8'd0, 8'h00);
    add_step(op_rd, a_ctrl, 8'h00, 8'h3c);
    add_step(op_frame, 14'd0, 8'd1, 8'(BUFFER_END));
    add_step(op_wr, a_ctrl, 8'h00, 8'h00);
    add_step(op_idle, 14'd0, 8'd0, 8'h00);
    add_step(op_rd, a_ctrl, 8'h00, 8'h00);
    // sync_start with run clear streams bank 1 from the front buffer
    add_step(op_sync, 14'd0, 8'd0, 8'h00);
    add_step(op_frame, 14'd1, 8'd0, 8'(BUFFER_END));
    add_step(op_idle, 14'd0, 8'd0, 8'h00);
    add_step(op_rd, a_ctrl, 8'h00, 8'h00);
    // Init wins over the other bits written with it
    add_step(op_wr, a_ctrl, 8'h15, 8'h00);
    add_step(op_busy, 14'd0, 8'd0, 8'h00);
    add_step(op_idle, 14'd0, 8'd0, 8'(TRESET));
    add_step(op_rd, a_ctrl, 8'h00, 8'h00);
    add_step(op_rd, a_status, 8'h00, 8'h00);
  endtask

  // Sample dout on the falling edge away from the register updates
  always @(negedge busClk) begin
    if (dout === 1'b1) begin
      high_cnt = high_cnt + 1;
      low_cnt  = 0;
    end else begin
      if (high_cnt != 0) begin
        check(high_cnt == T0H || high_cnt == T1H, 1'b1, "dout pulse width");
        rx_byte  = {rx_byte[6:0], high_cnt == T1H};
        rx_bits  = rx_bits + 1;
        got_bits = 1'b1;
        high_cnt = 0;
        if (rx_bits == 8) begin
          rx_q.push_back(rx_byte);
          rx_bits = 0;
        end
      end
      low_cnt = low_cnt + 1;
      // Latch low after data closes the frame
      if (low_cnt == TRESET && got_bits) begin
        check(rx_bits, 0, "bits left over at frame end");
        got_bits = 1'b0;
        frames   = frames + 1;
      end
    end
  end

  initial begin
    wait (table_ready);
    repeat (steps.size() * FRAME_CYCLES + 1000) @(posedge busClk);
    $display("Timeout: the test steps did not complete in the allowed time");
    $display("ERRORS FOUND");
    $fatal(1, "watchdog expired");
  end

  initial begin
    int         s;
    logic [7:0] rd;
    step_t      st;
    time        busy_t;
    bus        = '0;
    sync_start = 1'b0;
    rst        = 1'b1;
    busy_t     = 0;
    build_table();
    table_ready = 1'b1;
    repeat (10) @(posedge busClk);
    #1 rst = 1'b0;
    for (s = 0; s < steps.size(); s++) begin
      st = steps[s];
      case (st.op)
        op_wr:    bus_write(st.addr, st.data);
        op_rd: begin
          bus_read(st.addr, rd);
          check(rd, st.exp, $sformatf("register read at %h", st.addr));
        end
        op_rdm: begin
          bus_read(st.addr, rd);
          check(rd, model[st.data[0]][st.addr[3:0]], "pixel buffer readback");
        end
        op_fill:  fill_buffer(st.data[0]);
        op_frame: wait_frame(st.addr[0], st.data[0], st.exp);
        op_busy: begin
          wait_status(1'b1);
          busy_t = $time;
        end
        op_idle: begin
          wait_status(1'b0);
          // A nonzero exp is the least number of cycles the FSM stayed busy
          if (st.exp != 0) begin
            check(($time - busy_t) >= st.exp * CLK_PERIOD, 1'b1, "init reset low period");
          end
        end
        op_next:  wait (got_bits);
        default:  pulse_sync();
      endcase
    end
    check(rx_q.size(), 0, "bytes on dout outside a checked frame");
    $display("NO ERRORS");
    $finish;
  end

endmodule

/* list.f */
neopixel_pkg.sv
neopixel_bit_encoder.sv
neopixel_registers.sv
neopixel_streamer.sv
neopixel_top.sv
neopixel_tb.sv
